/* decode_pkg.sv */
package decode_pkg;

    localparam int word_w     = 32;
    localparam int reg_addr_w = 5;

    typedef logic [word_w-1:0]     word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // JAL writes its return address here
    localparam reg_addr_t link_reg = 5'd31;

    // REGIMM rt field
    localparam reg_addr_t rt_bltz = 5'd0;
    localparam reg_addr_t rt_bgez = 5'd1;

    typedef enum logic [5:0] {
        op_special = 6'h00, op_regimm = 6'h01, op_j     = 6'h02, op_jal   = 6'h03,
        op_beq     = 6'h04, op_bne    = 6'h05, op_blez  = 6'h06, op_bgtz  = 6'h07,
        op_addi    = 6'h08, op_addiu  = 6'h09, op_slti  = 6'h0a, op_sltiu = 6'h0b,
        op_andi    = 6'h0c, op_ori    = 6'h0d, op_xori  = 6'h0e, op_lui   = 6'h0f,
        op_lb      = 6'h20, op_lh     = 6'h21, op_lw    = 6'h23, op_lbu   = 6'h24,
        op_lhu     = 6'h25, op_sb     = 6'h28, op_sh    = 6'h29, op_sw    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        fn_sll  = 6'h00, fn_srl  = 6'h02, fn_sra  = 6'h03, fn_sllv = 6'h04,
        fn_srlv = 6'h06, fn_srav = 6'h07, fn_jr   = 6'h08, fn_jalr = 6'h09,
        fn_add  = 6'h20, fn_addu = 6'h21, fn_sub  = 6'h22, fn_subu = 6'h23,
        fn_and  = 6'h24, fn_or   = 6'h25, fn_xor  = 6'h26, fn_nor  = 6'h27,
        fn_slt  = 6'h2a, fn_sltu = 6'h2b
    } funct_e;

    // Zero must stay the NOP so a cleared packet is a bubble
    typedef enum logic [5:0] {
        alu_nop = 6'd0,
        alu_and, alu_or, alu_xor, alu_nor,
        alu_sll, alu_srl, alu_sra,
        alu_add, alu_addu, alu_sub, alu_subu, alu_slt, alu_sltu, alu_addi, alu_addiu,
        alu_lb, alu_lbu, alu_lh, alu_lhu, alu_lw, alu_sb, alu_sh, alu_sw,
        alu_j, alu_jal, alu_jr, alu_jalr,
        alu_beq, alu_bne, alu_bgtz, alu_blez, alu_bgez, alu_bltz
    } alu_op_e;

    typedef enum logic [2:0] {
        sel_nop = 3'd0, sel_logic, sel_shift, sel_arith, sel_load_store, sel_jump_branch
    } alu_sel_e;

    typedef struct packed {
        logic      wreg;
        reg_addr_t waddr;
        word_t     wdata;
        alu_op_e   alu_op;
    } fwd_t;

    typedef struct packed {
        alu_op_e   alu_op;
        alu_sel_e  alu_sel;
        logic      reg1_read;
        logic      reg2_read;
        reg_addr_t reg1_addr;
        reg_addr_t reg2_addr;
        reg_addr_t wd;
        logic      wreg;
        word_t     imm;
    } dec_t;

    typedef struct packed {
        logic  flag;
        word_t target;
        logic  next_in_delay_slot;
    } branch_t;

    typedef struct packed {
        alu_op_e   alu_op;
        alu_sel_e  alu_sel;
        word_t     src1;
        word_t     src2;
        reg_addr_t wd;
        logic      wreg;
        word_t     link_addr;
        logic      in_delay_slot;
        word_t     inst;
    } id_ex_t;

    function automatic logic is_load_op(alu_op_e op);
        return op inside {alu_lb, alu_lbu, alu_lh, alu_lhu, alu_lw};
    endfunction

endpackage

/* inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder
    import decode_pkg::*;
(
    input  word_t inst_i,
    output dec_t  dec_o
);

    opcode_e   op;
    funct_e    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    reg_addr_t sa;
    logic [15:0] imm16;

    alu_op_e  sp_op;
    alu_op_e  alu_op;
    alu_sel_e alu_sel;
    logic     sa_shift;

    assign op    = opcode_e'(inst_i[31:26]);
    assign rs    = inst_i[25:21];
    assign rt    = inst_i[20:16];
    assign rd    = inst_i[15:11];
    assign sa    = inst_i[10:6];
    assign funct = funct_e'(inst_i[5:0]);
    assign imm16 = inst_i[15:0];

    assign sa_shift = funct inside {fn_sll, fn_srl, fn_sra};

    // SPECIAL group by function field
    always_comb begin
        case (funct)
            fn_sll, fn_sllv: sp_op = alu_sll;
            fn_srl, fn_srlv: sp_op = alu_srl;
            fn_sra, fn_srav: sp_op = alu_sra;
            fn_jr:           sp_op = alu_jr;
            fn_jalr:         sp_op = alu_jalr;
            fn_add:          sp_op = alu_add;
            fn_addu:         sp_op = alu_addu;
            fn_sub:          sp_op = alu_sub;
            fn_subu:         sp_op = alu_subu;
            fn_and:          sp_op = alu_and;
            fn_or:           sp_op = alu_or;
            fn_xor:          sp_op = alu_xor;
            fn_nor:          sp_op = alu_nor;
            fn_slt:          sp_op = alu_slt;
            fn_sltu:         sp_op = alu_sltu;
            default:         sp_op = alu_nop;
        endcase
    end

    always_comb begin
        alu_op = alu_nop;
        case (op)
            op_special: begin
                // Shift by sa needs rs zero, the rest need sa zero
                if (sa_shift ? (rs == 5'd0) : (sa == 5'd0)) begin
                    alu_op = sp_op;
                end
            end
            op_regimm: begin
                if (rt == rt_bltz) begin
                    alu_op = alu_bltz;
                end else if (rt == rt_bgez) begin
                    alu_op = alu_bgez;
                end
            end
            op_j:            alu_op = alu_j;
            op_jal:          alu_op = alu_jal;
            op_beq:          alu_op = alu_beq;
            op_bne:          alu_op = alu_bne;
            op_blez:         alu_op = alu_blez;
            op_bgtz:         alu_op = alu_bgtz;
            op_addi:         alu_op = alu_addi;
            op_addiu:        alu_op = alu_addiu;
            op_slti:         alu_op = alu_slt;
            op_sltiu:        alu_op = alu_sltu;
            op_andi:         alu_op = alu_and;
            op_ori, op_lui:  alu_op = alu_or;
            op_xori:         alu_op = alu_xor;
            op_lb:           alu_op = alu_lb;
            op_lbu:          alu_op = alu_lbu;
            op_lh:           alu_op = alu_lh;
            op_lhu:          alu_op = alu_lhu;
            op_lw:           alu_op = alu_lw;
            op_sb:           alu_op = alu_sb;
            op_sh:           alu_op = alu_sh;
            op_sw:           alu_op = alu_sw;
            default:         alu_op = alu_nop;
        endcase
    end

    always_comb begin
        case (alu_op)
            alu_and, alu_or, alu_xor, alu_nor: alu_sel = sel_logic;
            alu_sll, alu_srl, alu_sra:         alu_sel = sel_shift;
            alu_add, alu_addu, alu_sub, alu_subu,
            alu_slt, alu_sltu, alu_addi, alu_addiu: alu_sel = sel_arith;
            alu_lb, alu_lbu, alu_lh, alu_lhu, alu_lw,
            alu_sb, alu_sh, alu_sw:            alu_sel = sel_load_store;
            alu_j, alu_jal, alu_jr, alu_jalr, alu_beq, alu_bne,
            alu_bgtz, alu_blez, alu_bgez, alu_bltz: alu_sel = sel_jump_branch;
            default:                           alu_sel = sel_nop;
        endcase
    end

    always_comb begin
        dec_o           = '0;
        dec_o.reg1_addr = rs;
        dec_o.reg2_addr = rt;
        if (alu_op != alu_nop) begin
            dec_o.alu_op  = alu_op;
            dec_o.alu_sel = alu_sel;
            case (op)
                op_special: begin
                    dec_o.reg1_read = !sa_shift;
                    dec_o.reg2_read = !(funct inside {fn_jr, fn_jalr});
                    dec_o.wd        = rd;
                    dec_o.wreg      = (funct != fn_jr);
                    dec_o.imm       = sa_shift ? {27'd0, sa} : '0;
                end
                op_regimm, op_blez, op_bgtz: dec_o.reg1_read = 1'b1;
                op_beq, op_bne, op_sb, op_sh, op_sw: begin
                    dec_o.reg1_read = 1'b1;
                    dec_o.reg2_read = 1'b1;
                end
                op_jal: begin
                    dec_o.wd   = link_reg;
                    dec_o.wreg = 1'b1;
                end
                op_j: ;
                default: begin
                    // I-type writing rt
                    dec_o.reg1_read = 1'b1;
                    dec_o.wd        = rt;
                    dec_o.wreg      = 1'b1;
                    if (op inside {op_addi, op_addiu, op_slti, op_sltiu}) begin
                        dec_o.imm = {{16{imm16[15]}}, imm16};
                    end else if (op inside {op_andi, op_ori, op_xori}) begin
                        dec_o.imm = {16'h0, imm16};
                    end else if (op == op_lui) begin
                        dec_o.imm = {imm16, 16'h0};
                    end
                end
            endcase
        end
    end

endmodule

/* operand_forward.sv */
`timescale 1ns/1ps

module operand_forward
    import decode_pkg::*;
(
    input  dec_t  dec_i,
    input  word_t rf_rdata1_i,
    input  word_t rf_rdata2_i,
    input  fwd_t  ex_fwd_i,
    input  fwd_t  mem_fwd_i,
    output word_t src1_o,
    output word_t src2_o,
    output logic  stall_o
);

    logic ex_load;

    // EX result wins over MEM, MEM over the register file
    function automatic word_t resolve(logic rd_en, reg_addr_t addr, word_t rf_data,
                                      word_t imm, fwd_t ex, fwd_t mem);
        if (!rd_en) begin
            return imm;
        end else if (ex.wreg && ex.waddr == addr) begin
            return ex.wdata;
        end else if (mem.wreg && mem.waddr == addr) begin
            return mem.wdata;
        end
        return rf_data;
    endfunction

    assign src1_o = resolve(dec_i.reg1_read, dec_i.reg1_addr, rf_rdata1_i, dec_i.imm,
                            ex_fwd_i, mem_fwd_i);
    assign src2_o = resolve(dec_i.reg2_read, dec_i.reg2_addr, rf_rdata2_i, dec_i.imm,
                            ex_fwd_i, mem_fwd_i);

    // Load data only exists after MEM
    assign ex_load = ex_fwd_i.wreg && is_load_op(ex_fwd_i.alu_op);
    assign stall_o = ex_load &&
                     ((dec_i.reg1_read && ex_fwd_i.waddr == dec_i.reg1_addr) ||
                      (dec_i.reg2_read && ex_fwd_i.waddr == dec_i.reg2_addr));

endmodule

/* branch_unit.sv */
`timescale 1ns/1ps

module branch_unit
    import decode_pkg::*;
(
    input  word_t   pc_i,
    input  word_t   inst_i,
    input  dec_t    dec_i,
    input  word_t   src1_i,
    input  word_t   src2_i,
    input  logic    stall_i,
    output branch_t branch_o,
    output word_t   link_addr_o
);

    word_t pc_plus_4;
    word_t pc_plus_8;
    word_t br_offset;
    word_t jump_target;
    word_t target;
    logic  taken;

    assign pc_plus_4   = pc_i + 32'd4;
    assign pc_plus_8   = pc_i + 32'd8;
    assign br_offset   = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
    assign jump_target = {pc_plus_4[31:28], inst_i[25:0], 2'b00};

    always_comb begin
        taken  = 1'b0;
        target = pc_plus_4 + br_offset;
        case (dec_i.alu_op)
            alu_j, alu_jal: begin
                taken  = 1'b1;
                target = jump_target;
            end
            alu_jr, alu_jalr: begin
                taken  = 1'b1;
                target = src1_i;
            end
            alu_beq:  taken = (src1_i == src2_i);
            alu_bne:  taken = (src1_i != src2_i);
            alu_bgtz: taken = !src1_i[31] && (src1_i != '0);
            alu_blez: taken = src1_i[31] || (src1_i == '0);
            alu_bgez: taken = !src1_i[31];
            alu_bltz: taken = src1_i[31];
            default:  taken = 1'b0;
        endcase
    end

    // No redirect while the stage is stalled
    assign branch_o.flag               = taken && !stall_i;
    assign branch_o.next_in_delay_slot = taken && !stall_i;
    assign branch_o.target             = taken ? target : '0;

    assign link_addr_o = (dec_i.alu_op inside {alu_jal, alu_jalr}) ? pc_plus_8 : '0;

endmodule

/* id_ex_reg.sv */
`timescale 1ns/1ps

module id_ex_reg
    import decode_pkg::*;
(
    input  logic   clk_i,
    input  logic   arst_n_i,
    input  logic   stall_i,
    input  dec_t   dec_i,
    input  word_t  src1_i,
    input  word_t  src2_i,
    input  word_t  link_addr_i,
    input  logic   in_delay_slot_i,
    input  word_t  inst_i,
    output id_ex_t id_ex_o
);

    id_ex_t next_pkt;
    logic   bubble;

    // Undecoded words travel as a bubble too
    assign bubble = stall_i || (dec_i.alu_op == alu_nop);

    always_comb begin
        next_pkt = '0;
        if (!bubble) begin
            next_pkt.alu_op        = dec_i.alu_op;
            next_pkt.alu_sel       = dec_i.alu_sel;
            next_pkt.src1          = src1_i;
            next_pkt.src2          = src2_i;
            next_pkt.wd            = dec_i.wd;
            next_pkt.wreg          = dec_i.wreg;
            next_pkt.link_addr     = link_addr_i;
            next_pkt.in_delay_slot = in_delay_slot_i;
            next_pkt.inst          = inst_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_o <= '0;
        end else begin
            id_ex_o <= next_pkt;
        end
    end

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps

module decode_stage
    import decode_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  word_t     pc_i,
    input  word_t     inst_i,
    input  logic      in_delay_slot_i,
    input  word_t     rf_rdata1_i,
    input  word_t     rf_rdata2_i,
    input  fwd_t      ex_fwd_i,
    input  fwd_t      mem_fwd_i,
    output reg_addr_t rf_raddr1_o,
    output reg_addr_t rf_raddr2_o,
    output logic      stall_o,
    output branch_t   branch_o,
    output id_ex_t    id_ex_o
);

    dec_t  dec;
    word_t src1;
    word_t src2;
    word_t link_addr;

    inst_decoder u_inst_decoder (
        .inst_i (inst_i),
        .dec_o  (dec)
    );

    // Register file answers in the same cycle
    assign rf_raddr1_o = dec.reg1_addr;
    assign rf_raddr2_o = dec.reg2_addr;

    operand_forward u_operand_forward (
        .dec_i       (dec),
        .rf_rdata1_i (rf_rdata1_i),
        .rf_rdata2_i (rf_rdata2_i),
        .ex_fwd_i    (ex_fwd_i),
        .mem_fwd_i   (mem_fwd_i),
        .src1_o      (src1),
        .src2_o      (src2),
        .stall_o     (stall_o)
    );

    branch_unit u_branch_unit (
        .pc_i        (pc_i),
        .inst_i      (inst_i),
        .dec_i       (dec),
        .src1_i      (src1),
        .src2_i      (src2),
        .stall_i     (stall_o),
        .branch_o    (branch_o),
        .link_addr_o (link_addr)
    );

    id_ex_reg u_id_ex_reg (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .stall_i         (stall_o),
        .dec_i           (dec),
        .src1_i          (src1),
        .src2_i          (src2),
        .link_addr_i     (link_addr),
        .in_delay_slot_i (in_delay_slot_i),
        .inst_i          (inst_i),
        .id_ex_o         (id_ex_o)
    );

endmodule

/* decode_model.svh */
word_t   regs [32];
logic    exp_stall;
branch_t exp_br;
id_ex_t  exp_pkt;

function automatic alu_op_e expect_op(word_t w);
    alu_op_e op;
    logic    sh;
    op = alu_nop;
    sh = w[5:0] inside {fn_sll, fn_srl, fn_sra};
    case (w[31:26])
        op_special: begin
            // Constant shifts need rs zero, the others need sa zero
            if (sh ? (w[25:21] == 5'd0) : (w[10:6] == 5'd0)) begin
                case (w[5:0])
                    fn_sll, fn_sllv: op = alu_sll;
                    fn_srl, fn_srlv: op = alu_srl;
                    fn_sra, fn_srav: op = alu_sra;
                    fn_jr:           op = alu_jr;
                    fn_jalr:         op = alu_jalr;
                    fn_add:          op = alu_add;
                    fn_addu:         op = alu_addu;
                    fn_sub:          op = alu_sub;
                    fn_subu:         op = alu_subu;
                    fn_and:          op = alu_and;
                    fn_or:           op = alu_or;
                    fn_xor:          op = alu_xor;
                    fn_nor:          op = alu_nor;
                    fn_slt:          op = alu_slt;
                    fn_sltu:         op = alu_sltu;
                    default:         op = alu_nop;
                endcase
            end
        end
        op_regimm: begin
            if (w[20:16] == 5'd0) begin
                op = alu_bltz;
            end else if (w[20:16] == 5'd1) begin
                op = alu_bgez;
            end
        end
        op_j:           op = alu_j;
        op_jal:         op = alu_jal;
        op_beq:         op = alu_beq;
        op_bne:         op = alu_bne;
        op_blez:        op = alu_blez;
        op_bgtz:        op = alu_bgtz;
        op_addi:        op = alu_addi;
        op_addiu:       op = alu_addiu;
        op_slti:        op = alu_slt;
        op_sltiu:       op = alu_sltu;
        op_andi:        op = alu_and;
        op_ori, op_lui: op = alu_or;
        op_xori:        op = alu_xor;
        op_lb:          op = alu_lb;
        op_lbu:         op = alu_lbu;
        op_lh:          op = alu_lh;
        op_lhu:         op = alu_lhu;
        op_lw:          op = alu_lw;
        op_sb:          op = alu_sb;
        op_sh:          op = alu_sh;
        op_sw:          op = alu_sw;
        default:        op = alu_nop;
    endcase
    return op;
endfunction

function automatic alu_sel_e expect_sel(alu_op_e op);
    return (op == alu_nop) ? sel_nop :
           (op inside {alu_and, alu_or, alu_xor, alu_nor}) ? sel_logic :
           (op inside {alu_sll, alu_srl, alu_sra}) ? sel_shift :
           (op inside {alu_lb, alu_lbu, alu_lh, alu_lhu, alu_lw,
                       alu_sb, alu_sh, alu_sw}) ? sel_load_store :
           (op inside {alu_j, alu_jal, alu_jr, alu_jalr, alu_beq, alu_bne,
                       alu_bgtz, alu_blez, alu_bgez, alu_bltz}) ? sel_jump_branch :
           sel_arith;
endfunction

// EX first, then MEM, then the register array
function automatic word_t pick_src(logic rd_en, reg_addr_t a, word_t imm, fwd_t ex, fwd_t mem);
    return !rd_en ? imm :
           (ex.wreg && ex.waddr == a) ? ex.wdata :
           (mem.wreg && mem.waddr == a) ? mem.wdata : regs[a];
endfunction

task automatic predict(input word_t pc_v, input word_t w, input logic ds,
                       input fwd_t ex, input fwd_t mem);
    alu_op_e aop;
    logic    r_type;
    logic    sh;
    logic    rd1;
    logic    rd2;
    logic    taken;
    word_t   imm;
    word_t   s1;
    word_t   s2;
    word_t   pc4;
    word_t   tgt;
    aop    = expect_op(w);
    r_type = (w[31:26] == op_special);
    sh     = r_type && (w[5:0] inside {fn_sll, fn_srl, fn_sra});
    rd1    = !(aop inside {alu_nop, alu_j, alu_jal}) && !sh;
    rd2    = r_type ? !(aop inside {alu_nop, alu_jr, alu_jalr}) :
                      (aop inside {alu_beq, alu_bne, alu_sb, alu_sh, alu_sw});
    case (w[31:26])
        op_addi, op_addiu, op_slti, op_sltiu: imm = {{16{w[15]}}, w[15:0]};
        op_andi, op_ori, op_xori:             imm = {16'h0, w[15:0]};
        op_lui:                               imm = {w[15:0], 16'h0};
        default:                              imm = sh ? {27'd0, w[10:6]} : '0;
    endcase
    exp_stall = ex.wreg && (ex.alu_op inside {alu_lb, alu_lbu, alu_lh, alu_lhu, alu_lw}) &&
                ((rd1 && ex.waddr == w[25:21]) || (rd2 && ex.waddr == w[20:16]));
    s1    = pick_src(rd1, w[25:21], imm, ex, mem);
    s2    = pick_src(rd2, w[20:16], imm, ex, mem);
    pc4   = pc_v + 32'd4;
    tgt   = pc4 + {{14{w[15]}}, w[15:0], 2'b00};
    taken = 1'b0;
    case (aop)
        alu_j, alu_jal: begin
            taken = 1'b1;
            tgt   = {pc4[31:28], w[25:0], 2'b00};
        end
        alu_jr, alu_jalr: begin
            taken = 1'b1;
            tgt   = s1;
        end
        alu_beq:  taken = (s1 == s2);
        alu_bne:  taken = (s1 != s2);
        alu_bgtz: taken = $signed(s1) > 0;
        alu_blez: taken = $signed(s1) <= 0;
        alu_bgez: taken = $signed(s1) >= 0;
        alu_bltz: taken = $signed(s1) < 0;
        default:  taken = 1'b0;
    endcase
    exp_br.flag               = taken && !exp_stall;
    exp_br.next_in_delay_slot = taken && !exp_stall;
    exp_br.target             = tgt;
    exp_pkt = '0;
    if (aop != alu_nop && !exp_stall) begin
        exp_pkt.alu_op        = aop;
        exp_pkt.alu_sel       = expect_sel(aop);
        exp_pkt.src1          = s1;
        exp_pkt.src2          = s2;
        exp_pkt.wd            = (aop == alu_jal) ? link_reg : r_type ? w[15:11] : w[20:16];
        exp_pkt.wreg          = !(aop inside {alu_j, alu_jr, alu_beq, alu_bne, alu_bgtz,
                                              alu_blez, alu_bgez, alu_bltz,
                                              alu_sb, alu_sh, alu_sw});
        exp_pkt.link_addr     = (aop inside {alu_jal, alu_jalr}) ? pc_v + 32'd8 : '0;
        exp_pkt.in_delay_slot = ds;
        exp_pkt.inst          = w;
    end
endtask

/* tb_decode_stage.sv */
`timescale 1ns/1ps

module tb_decode_stage
    import decode_pkg::*;
();

    localparam int num_insts    = 2000;
    localparam int reset_cycles = 4;
    // Reset plus one cycle per instruction, with some margin
    localparam int max_cycles   = reset_cycles + num_insts + 96;

    logic      clk = 1'b0;
    logic      arst_n;
    word_t     pc;
    word_t     instr;
    logic      in_ds;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    fwd_t      ex_fwd;
    fwd_t      mem_fwd;
    reg_addr_t rf_raddr1;
    reg_addr_t rf_raddr2;
    logic      stall;
    branch_t   branch;
    id_ex_t    id_ex;
    integer    seed;
    int        cycles = 0;
    int        fails = 0;
    logic      hold;
    word_t     rnd;

    `include "decode_model.svh"

    decode_stage dut (
        .clk_i           (clk),
        .arst_n_i        (arst_n),
        .pc_i            (pc),
        .inst_i          (instr),
        .in_delay_slot_i (in_ds),
        .rf_rdata1_i     (rf_rdata1),
        .rf_rdata2_i     (rf_rdata2),
        .ex_fwd_i        (ex_fwd),
        .mem_fwd_i       (mem_fwd),
        .rf_raddr1_o     (rf_raddr1),
        .rf_raddr2_o     (rf_raddr2),
        .stall_o         (stall),
        .branch_o        (branch),
        .id_ex_o         (id_ex)
    );

    assign rf_rdata1 = regs[rf_raddr1];
    assign rf_rdata2 = regs[rf_raddr2];

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", max_cycles);
            $display("*** FAILED ***");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string name, input logic [31:0] act,
                               input logic [31:0] exp);
        if (act !== exp) begin
            fails++;
            $display("MISMATCH %s: actual 0x%h expected 0x%h", name, act, exp);
            $display("*** FAILED ***");
            $fatal(1, "check failed on %s", name);
        end
    endtask

    task automatic check_packet();
        check_value("id_ex_o.alu_op", 32'(id_ex.alu_op), 32'(exp_pkt.alu_op));
        check_value("id_ex_o.alu_sel", 32'(id_ex.alu_sel), 32'(exp_pkt.alu_sel));
        check_value("id_ex_o.src1", id_ex.src1, exp_pkt.src1);
        check_value("id_ex_o.src2", id_ex.src2, exp_pkt.src2);
        check_value("id_ex_o.wreg", 32'(id_ex.wreg), 32'(exp_pkt.wreg));
        // A bubble carries a zero destination as well
        if (exp_pkt.wreg || exp_pkt.alu_op == alu_nop) begin
            check_value("id_ex_o.wd", 32'(id_ex.wd), 32'(exp_pkt.wd));
        end
        check_value("id_ex_o.link_addr", id_ex.link_addr, exp_pkt.link_addr);
        check_value("id_ex_o.in_delay_slot", 32'(id_ex.in_delay_slot),
                    32'(exp_pkt.in_delay_slot));
        check_value("id_ex_o.inst", id_ex.inst, exp_pkt.inst);
    endtask

    // Kept instruction most of the time, raw random word otherwise
    task automatic make_inst(output word_t w);
        word_t   r;
        opcode_e op;
        funct_e  fn;
        w = $random(seed);
        r = $random(seed);
        if (r[3:0] != 4'd0) begin
            op = op.first();
            repeat (r[15:4] % op.num()) begin
                op = op.next();
            end
            fn = fn.first();
            repeat (r[31:16] % fn.num()) begin
                fn = fn.next();
            end
            w[31:26] = op;
            if (op == op_special) begin
                w[5:0] = fn;
                if (fn inside {fn_sll, fn_srl, fn_sra}) begin
                    w[25:21] = 5'd0;
                end else begin
                    w[10:6] = 5'd0;
                end
            end else if (op == op_regimm) begin
                w[20:17] = 4'd0;
            end
        end
    endtask

    // Destination often aimed at rs or rt
    task automatic make_fwd(output fwd_t f, input reg_addr_t rs, input reg_addr_t rt);
        word_t r;
        r        = $random(seed);
        f.wreg   = r[0] | r[1];
        f.waddr  = (r[3:2] == 2'd0) ? rs : (r[3:2] == 2'd1) ? rt : r[8:4];
        f.alu_op = alu_op_e'(r[15:10] % 6'd34);
        f.wdata  = $random(seed);
    endtask

    initial begin
        seed    = 77;
        arst_n  = 1'b0;
        pc      = '0;
        instr   = '0;
        in_ds   = 1'b0;
        ex_fwd  = '0;
        mem_fwd = '0;
        hold    = 1'b0;
        foreach (regs[i]) begin
            regs[i] = $random(seed);
        end
        repeat (reset_cycles) @(negedge clk);
        exp_pkt = '0;
        check_packet();
        check_value("branch_o.flag", 32'(branch.flag), 32'd0);
        arst_n = 1'b1;

        for (int n = 0; n < num_insts; n++) begin
            // A stalled instruction is held by the fetch side
            if (!hold) begin
                make_inst(instr);
                rnd   = $random(seed);
                pc    = {rnd[31:2], 2'b00};
                rnd   = $random(seed);
                in_ds = rnd[0];
            end
            make_fwd(ex_fwd, instr[25:21], instr[20:16]);
            make_fwd(mem_fwd, instr[25:21], instr[20:16]);
            #1;
            // Read requests name rs and rt
            check_value("rf_raddr1_o", 32'(rf_raddr1), 32'(instr[25:21]));
            check_value("rf_raddr2_o", 32'(rf_raddr2), 32'(instr[20:16]));
            predict(pc, instr, in_ds, ex_fwd, mem_fwd);
            check_value("stall_o", 32'(stall), 32'(exp_stall));
            check_value("branch_o.flag", 32'(branch.flag), 32'(exp_br.flag));
            check_value("branch_o.next_in_delay_slot", 32'(branch.next_in_delay_slot),
                        32'(exp_br.next_in_delay_slot));
            if (exp_br.flag) begin
                check_value("branch_o.target", branch.target, exp_br.target);
            end
            hold = exp_stall;
            @(negedge clk);
            check_packet();
        end

        if (fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+.
decode_pkg.sv
inst_decoder.sv
operand_forward.sv
branch_unit.sv
id_ex_reg.sv
decode_stage.sv
tb_decode_stage.sv
